/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       := mixed_radix_bfly_tb
FILELIST  := mixed_radix_bfly.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/bfly_cfg.svh */
`ifndef BFLY_CFG_SVH
`define BFLY_CFG_SVH

// sample width at the ports
`define BFLY_SAMPLE_W 18
`define BFLY_LANES 4

// one bit of growth per adder stage
`define BFLY_S1_W 19
`define BFLY_S2_W 20

// block exponent, wraps modulo 16
`define BFLY_EXP_W 4
`define BFLY_MARGIN_W 2

// worst-case growth in bits per radix
`define BFLY_GROWTH_R4 2
`define BFLY_GROWTH_R2 1

`endif

/* mixed_radix_bfly.f */
+incdir+include
source/bfly_num_pkg.sv
source/bfly_ctl_pkg.sv
source/bfly_ctrl.sv
source/lane_permute_add.sv
source/radix4_combine.sv
source/growth_scaler.sv
source/mixed_radix_bfly.sv
testbench/tb_clock_gen.sv
testbench/mixed_radix_bfly_tb.sv

/* source/bfly_ctl_pkg.sv */
`include "bfly_cfg.svh"

package bfly_ctl_pkg;

	// codes match the radix value itself, unknown codes run as radix 4
	typedef enum logic [2:0] {
		RADIX_2 = 3'd2,
		RADIX_4 = 3'd4
	} radix_e;

	// one item as it enters the butterfly
	typedef struct packed {
		bfly_num_pkg::lanes_t lanes;
		radix_e radix;
		logic [`BFLY_MARGIN_W-1:0] margin;
		logic [`BFLY_EXP_W-1:0] exp;
	} bfly_item_t;

	// control that travels alongside the data, one copy per stage
	typedef struct packed {
		logic is_radix4;
		// shift applied by the scaler
		logic [`BFLY_MARGIN_W-1:0] shift;
		// exponent already updated with the growth
		logic [`BFLY_EXP_W-1:0] exp;
	} stage_ctl_t;

endpackage

/* source/bfly_ctrl.sv */
`include "bfly_cfg.svh"

module bfly_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic in_val_i,
	input  bfly_ctl_pkg::radix_e radix_i,
	input  logic [`BFLY_MARGIN_W-1:0] margin_i,
	input  logic [`BFLY_EXP_W-1:0] exp_i,
	output bfly_ctl_pkg::stage_ctl_t s1_ctl_o,
	output bfly_ctl_pkg::stage_ctl_t s2_ctl_o,
	output bfly_ctl_pkg::stage_ctl_t sc_ctl_o,
	output logic out_val_o,
	output logic [`BFLY_EXP_W-1:0] exp_out_o
);

	logic is_radix4;
	logic [`BFLY_MARGIN_W-1:0] worst_growth;
	logic [`BFLY_MARGIN_W-1:0] word_growth;
	// one valid bit per pipeline stage
	logic [2:0] val_q;

	assign is_radix4 = (radix_i != bfly_ctl_pkg::RADIX_2);
	assign worst_growth = is_radix4 ? `BFLY_MARGIN_W'(`BFLY_GROWTH_R4) :
		`BFLY_MARGIN_W'(`BFLY_GROWTH_R2);

	// margin already reserved in the input eats into the growth
	assign word_growth = (worst_growth > margin_i) ? worst_growth - margin_i : '0;

	// stage-1 control is decoded straight from the item
	always_comb begin
		s1_ctl_o.is_radix4 = is_radix4;
		s1_ctl_o.shift = word_growth;
		s1_ctl_o.exp = exp_i + `BFLY_EXP_W'(word_growth);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q <= '0;
			s2_ctl_o <= '0;
			sc_ctl_o <= '0;
			exp_out_o <= '0;
		end else begin
			val_q <= {val_q[1:0], in_val_i};
			s2_ctl_o <= s1_ctl_o;
			sc_ctl_o <= s2_ctl_o;
			// lands together with the scaled data, held otherwise
			if (val_q[1]) begin
				exp_out_o <= sc_ctl_o.exp;
			end
		end
	end

	assign out_val_o = val_q[2];

endmodule

/* source/bfly_num_pkg.sv */
`include "bfly_cfg.svh"

package bfly_num_pkg;

	typedef logic signed [`BFLY_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`BFLY_S1_W-1:0] sample_s1_t;
	typedef logic signed [`BFLY_S2_W-1:0] sample_s2_t;

	// complex sample at port width
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// after the sum/difference stage
	typedef struct packed {
		sample_s1_t re;
		sample_s1_t im;
	} cplx_s1_t;

	// after the radix-4 combine
	typedef struct packed {
		sample_s2_t re;
		sample_s2_t im;
	} cplx_s2_t;

	typedef cplx_t [`BFLY_LANES-1:0] lanes_t;
	typedef cplx_s1_t [`BFLY_LANES-1:0] lanes_s1_t;
	typedef cplx_s2_t [`BFLY_LANES-1:0] lanes_s2_t;

endpackage

/* source/growth_scaler.sv */
`include "bfly_cfg.svh"

module growth_scaler (
	input  logic clk,
	input  logic rst_n,
	input  bfly_num_pkg::lanes_s2_t lanes_i,
	input  bfly_ctl_pkg::stage_ctl_t ctl_i,
	output bfly_num_pkg::lanes_t lanes_o
);

	localparam bfly_num_pkg::sample_t SAT_HI = {1'b0, {(`BFLY_SAMPLE_W-1){1'b1}}};
	localparam bfly_num_pkg::sample_t SAT_LO = {1'b1, {(`BFLY_SAMPLE_W-1){1'b0}}};

	bfly_num_pkg::lanes_t nxt;

	// round half up, then clamp to the port range
	function automatic bfly_num_pkg::sample_t scale(
		input bfly_num_pkg::sample_s2_t v,
		input logic [`BFLY_MARGIN_W-1:0] g
	);
		// one extra bit so the rounding add cannot wrap
		logic signed [`BFLY_S2_W:0] w;
		logic signed [`BFLY_S2_W:0] rnd;
		bfly_num_pkg::sample_t r;
		w = v;
		if (g != '0) begin
			rnd = '0;
			rnd[g - 1] = 1'b1;
			w = (w + rnd) >>> g;
		end
		if (w > SAT_HI) begin
			r = SAT_HI;
		end else if (w < SAT_LO) begin
			r = SAT_LO;
		end else begin
			r = w[`BFLY_SAMPLE_W-1:0];
		end
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < `BFLY_LANES; i++) begin
			nxt[i].re = scale(lanes_i[i].re, ctl_i.shift);
			nxt[i].im = scale(lanes_i[i].im, ctl_i.shift);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lanes_o <= '0;
		end else begin
			lanes_o <= nxt;
		end
	end

endmodule

/* source/lane_permute_add.sv */
`include "bfly_cfg.svh"

module lane_permute_add (
	input  logic clk,
	input  logic rst_n,
	input  bfly_num_pkg::lanes_t lanes_i,
	input  bfly_ctl_pkg::stage_ctl_t ctl_i,
	output bfly_num_pkg::lanes_s1_t lanes_o
);

	// the two operand pairs after permutation
	bfly_num_pkg::cplx_t pa0, pa1, pb0, pb1;
	bfly_num_pkg::lanes_s1_t nxt;

	function automatic bfly_num_pkg::cplx_s1_t sum_diff(
		input bfly_num_pkg::cplx_t x,
		input bfly_num_pkg::cplx_t y,
		input logic sub
	);
		bfly_num_pkg::cplx_s1_t r;
		if (sub) begin
			r.re = x.re - y.re;
			r.im = x.im - y.im;
		end else begin
			r.re = x.re + y.re;
			r.im = x.im + y.im;
		end
		return r;
	endfunction

	// radix 4 pairs x0/x2 and x1/x3, radix 2 pairs neighbours
	always_comb begin
		pa0 = lanes_i[0];
		pb1 = lanes_i[3];
		if (ctl_i.is_radix4) begin
			pa1 = lanes_i[2];
			pb0 = lanes_i[1];
		end else begin
			pa1 = lanes_i[1];
			pb0 = lanes_i[2];
		end
		// sums low, differences high
		nxt[0] = sum_diff(pa0, pa1, 1'b0);
		nxt[1] = sum_diff(pb0, pb1, 1'b0);
		nxt[2] = sum_diff(pa0, pa1, 1'b1);
		nxt[3] = sum_diff(pb0, pb1, 1'b1);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lanes_o <= '0;
		end else begin
			lanes_o <= nxt;
		end
	end

endmodule

/* source/mixed_radix_bfly.sv */
`include "bfly_cfg.svh"

module mixed_radix_bfly (
	input  logic clk,
	input  logic rst_n,
	input  logic in_val_i,
	input  bfly_ctl_pkg::bfly_item_t in_item_i,
	output logic out_val_o,
	output bfly_num_pkg::lanes_t out_data_o,
	output logic [`BFLY_EXP_W-1:0] exp_out_o
);

	bfly_ctl_pkg::stage_ctl_t s1_ctl;
	bfly_ctl_pkg::stage_ctl_t s2_ctl;
	bfly_ctl_pkg::stage_ctl_t sc_ctl;
	bfly_num_pkg::lanes_s1_t s1_lanes;
	bfly_num_pkg::lanes_s2_t s2_lanes;

	bfly_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_val_i  (in_val_i),
		.radix_i   (in_item_i.radix),
		.margin_i  (in_item_i.margin),
		.exp_i     (in_item_i.exp),
		.s1_ctl_o  (s1_ctl),
		.s2_ctl_o  (s2_ctl),
		.sc_ctl_o  (sc_ctl),
		.out_val_o (out_val_o),
		.exp_out_o (exp_out_o)
	);

	// sum/difference pairs, one cycle
	lane_permute_add u_permute_add (
		.clk     (clk),
		.rst_n   (rst_n),
		.lanes_i (in_item_i.lanes),
		.ctl_i   (s1_ctl),
		.lanes_o (s1_lanes)
	);

	radix4_combine u_combine (
		.clk     (clk),
		.rst_n   (rst_n),
		.lanes_i (s1_lanes),
		.ctl_i   (s2_ctl),
		.lanes_o (s2_lanes)
	);

	growth_scaler u_scaler (
		.clk     (clk),
		.rst_n   (rst_n),
		.lanes_i (s2_lanes),
		.ctl_i   (sc_ctl),
		.lanes_o (out_data_o)
	);

endmodule

/* source/radix4_combine.sv */
module radix4_combine (
	input  logic clk,
	input  logic rst_n,
	input  bfly_num_pkg::lanes_s1_t lanes_i,
	input  bfly_ctl_pkg::stage_ctl_t ctl_i,
	output bfly_num_pkg::lanes_s2_t lanes_o
);

	bfly_num_pkg::cplx_s1_t a, b, c, d;
	bfly_num_pkg::lanes_s2_t nxt;

	always_comb begin
		a = lanes_i[0];
		b = lanes_i[1];
		c = lanes_i[2];
		d = lanes_i[3];
		if (ctl_i.is_radix4) begin
			nxt[0].re = a.re + b.re;
			nxt[0].im = a.im + b.im;
			// c - j*d
			nxt[1].re = c.re + d.im;
			nxt[1].im = c.im - d.re;
			nxt[2].re = a.re - b.re;
			nxt[2].im = a.im - b.im;
			// c + j*d
			nxt[3].re = c.re - d.im;
			nxt[3].im = c.im + d.re;
		end else begin
			// radix 2 just widens and interleaves sum/diff per pair
			nxt[0].re = a.re;
			nxt[0].im = a.im;
			nxt[1].re = c.re;
			nxt[1].im = c.im;
			nxt[2].re = b.re;
			nxt[2].im = b.im;
			nxt[3].re = d.re;
			nxt[3].im = d.im;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lanes_o <= '0;
		end else begin
			lanes_o <= nxt;
		end
	end

endmodule

/* testbench/mixed_radix_bfly_tb.sv */
`include "bfly_cfg.svh"

module mixed_radix_bfly_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ENT = 12;
	localparam int RST_CYCLES = 16;
	localparam int WATCHDOG_NS = (RST_CYCLES + N_ENT + 3 + 20) * 40;

	logic clk;
	logic rst_n;
	logic in_val;
	bfly_ctl_pkg::bfly_item_t in_item;
	logic out_val;
	bfly_num_pkg::lanes_t out_data;
	logic [`BFLY_EXP_W-1:0] exp_out;

	// one row per test with stimulus and expected values
	logic [2:0] tab_radix [N_ENT];
	logic [`BFLY_MARGIN_W-1:0] tab_margin [N_ENT];
	logic [`BFLY_EXP_W-1:0] tab_exp [N_ENT];
	bfly_num_pkg::lanes_t tab_lanes [N_ENT];
	bfly_num_pkg::lanes_t ref_lanes [N_ENT];
	logic [`BFLY_EXP_W-1:0] ref_exp [N_ENT];

	int apply_cyc [N_ENT];
	int cyc = 0;
	int next_check = 0;
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int seed;
	logic mon_en;
	logic [`BFLY_EXP_W-1:0] held_exp = '0;

	tb_clock_gen u_clk (
		.clk_o (clk)
	);

	mixed_radix_bfly uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_val_i   (in_val),
		.in_item_i  (in_item),
		.out_val_o  (out_val),
		.out_data_o (out_data),
		.exp_out_o  (exp_out)
	);

	// shift with round half up and clamp to 18 bits signed
	function automatic int scale_value(input int v, input int g);
		int r;
		r = v;
		if (g != 0) begin
			r = (v + (1 << (g - 1))) >>> g;
		end
		if (r > 131071) begin
			r = 131071;
		end else if (r < -131072) begin
			r = -131072;
		end
		return r;
	endfunction

	task automatic set_row(input int k, input logic [2:0] radix,
		input logic [`BFLY_MARGIN_W-1:0] margin, input logic [`BFLY_EXP_W-1:0] exp);
		tab_radix[k] = radix;
		tab_margin[k] = margin;
		tab_exp[k] = exp;
	endtask

	task automatic set_lane(input int k, input int lane, input int re, input int im);
		tab_lanes[k][lane].re = bfly_num_pkg::sample_t'(re);
		tab_lanes[k][lane].im = bfly_num_pkg::sample_t'(im);
	endtask

	// random lanes everywhere and then the edge rows
	task automatic fill_table();
		int r;
		for (int k = 0; k < N_ENT; k++) begin
			for (int i = 0; i < `BFLY_LANES; i++) begin
				r = $random(seed);
				tab_lanes[k][i].re = r[`BFLY_SAMPLE_W-1:0];
				r = $random(seed);
				tab_lanes[k][i].im = r[`BFLY_SAMPLE_W-1:0];
			end
		end
		set_row(0, 3'd4, 2'd0, 4'd3);
		set_row(1, 3'd2, 2'd0, 4'd7);
		set_row(2, 3'd4, 2'd0, 4'd15);
		set_row(3, 3'd2, 2'd0, 4'd15);
		set_row(4, 3'd4, 2'd2, 4'd5);
		set_row(5, 3'd2, 2'd1, 4'd2);
		set_row(6, 3'd4, 2'd3, 4'd9);
		set_row(7, 3'd2, 2'd0, 4'd11);
		set_row(8, 3'd4, 2'd1, 4'd14);
		set_row(9, 3'd2, 2'd2, 4'd0);
		set_row(10, 3'd4, 2'd0, 4'd6);
		set_row(11, 3'd7, 2'd0, 4'd12);
		for (int i = 0; i < `BFLY_LANES; i++) begin
			set_lane(4, i, 131071, 131071);
			set_lane(6, i, -131072, -131072);
			set_lane(10, i, 0, 0);
		end
		set_lane(5, 0, 131071, -131072);
		set_lane(5, 1, 131071, 131071);
		set_lane(5, 2, -131072, 0);
		set_lane(5, 3, 131071, 0);
		// ties on both signs
		set_lane(10, 0, 2, -2);
	endtask

	// expected lanes and exponent from the butterfly equations
	task automatic build_reference(input int k);
		int xr [4];
		int xi [4];
		int yr [4];
		int yi [4];
		int g;
		int e;
		logic is_r4;
		is_r4 = (tab_radix[k] != 3'd2);
		for (int i = 0; i < 4; i++) begin
			xr[i] = int'(tab_lanes[k][i].re);
			xi[i] = int'(tab_lanes[k][i].im);
		end
		if (is_r4) begin
			yr[0] = (xr[0] + xr[2]) + (xr[1] + xr[3]);
			yi[0] = (xi[0] + xi[2]) + (xi[1] + xi[3]);
			yr[1] = (xr[0] - xr[2]) + (xi[1] - xi[3]);
			yi[1] = (xi[0] - xi[2]) - (xr[1] - xr[3]);
			yr[2] = (xr[0] + xr[2]) - (xr[1] + xr[3]);
			yi[2] = (xi[0] + xi[2]) - (xi[1] + xi[3]);
			yr[3] = (xr[0] - xr[2]) - (xi[1] - xi[3]);
			yi[3] = (xi[0] - xi[2]) + (xr[1] - xr[3]);
		end else begin
			yr[0] = xr[0] + xr[1];
			yi[0] = xi[0] + xi[1];
			yr[1] = xr[0] - xr[1];
			yi[1] = xi[0] - xi[1];
			yr[2] = xr[2] + xr[3];
			yi[2] = xi[2] + xi[3];
			yr[3] = xr[2] - xr[3];
			yi[3] = xi[2] - xi[3];
		end
		g = (is_r4 ? 2 : 1) - int'(tab_margin[k]);
		if (g < 0) begin
			g = 0;
		end
		for (int i = 0; i < 4; i++) begin
			ref_lanes[k][i].re = bfly_num_pkg::sample_t'(scale_value(yr[i], g));
			ref_lanes[k][i].im = bfly_num_pkg::sample_t'(scale_value(yi[i], g));
		end
		e = int'(tab_exp[k]) + g;
		ref_exp[k] = e[`BFLY_EXP_W-1:0];
	endtask

	task automatic check_item(input int k);
		int errs;
		errs = 0;
		if (out_val !== 1'b1) begin
			$display("ERROR t=%0t: test %0d out_val_o low when its result was due", $time, k);
			errs++;
		end
		for (int i = 0; i < `BFLY_LANES; i++) begin
			if (out_data[i] !== ref_lanes[k][i]) begin
				$display("ERROR t=%0t: test %0d lane %0d got (%0d,%0d) expected (%0d,%0d)",
					$time, k, i, out_data[i].re, out_data[i].im,
					ref_lanes[k][i].re, ref_lanes[k][i].im);
				errs++;
			end
		end
		if (exp_out !== ref_exp[k]) begin
			$display("ERROR t=%0t: test %0d exp_out_o %0d expected %0d",
				$time, k, exp_out, ref_exp[k]);
			errs++;
		end
		held_exp = ref_exp[k];
		err_cnt += errs;
		if (errs == 0) begin
			pass_cnt++;
			$display("test %0d radix %0d margin %0d: ok", k, tab_radix[k], tab_margin[k]);
		end else begin
			fail_cnt++;
			$display("test %0d radix %0d margin %0d: wrong", k, tab_radix[k], tab_margin[k]);
		end
	endtask

	// with no result due the outputs stay idle and the exponent holds
	task automatic check_idle();
		if (out_val !== 1'b0) begin
			$display("ERROR t=%0t: out_val_o high with no item due", $time);
			err_cnt++;
		end
		if (exp_out !== held_exp) begin
			$display("ERROR t=%0t: exp_out_o %0d did not hold %0d", $time, exp_out, held_exp);
			err_cnt++;
		end
		if (next_check == 0 && out_data !== '0) begin
			$display("ERROR t=%0t: out_data_o not zero after reset", $time);
			err_cnt++;
		end
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (mon_en) begin
			if (next_check < N_ENT && apply_cyc[next_check] + 3 == cyc) begin
				check_item(next_check);
				next_check++;
			end else begin
				check_idle();
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out before all results arrived");
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		in_val = 1'b0;
		in_item = '0;
		mon_en = 1'b0;
		seed = 90;
		for (int k = 0; k < N_ENT; k++) begin
			apply_cyc[k] = 1000000;
		end
		fill_table();
		for (int k = 0; k < N_ENT; k++) begin
			build_reference(k);
		end
		// a live item during reset must leave no trace in the pipeline
		in_val = 1'b1;
		in_item.lanes = tab_lanes[N_ENT-1];
		in_item.radix = bfly_ctl_pkg::RADIX_4;
		in_item.exp = 4'd9;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		in_val = 1'b0;
		in_item = '0;
		mon_en = 1'b1;
		repeat (2) @(posedge clk);
		// one row per cycle back to back
		for (int k = 0; k < N_ENT; k++) begin
			@(posedge clk);
			#1;
			in_val = 1'b1;
			in_item.lanes = tab_lanes[k];
			in_item.radix = bfly_ctl_pkg::radix_e'(tab_radix[k]);
			in_item.margin = tab_margin[k];
			in_item.exp = tab_exp[k];
			apply_cyc[k] = cyc;
		end
		@(posedge clk);
		#1;
		in_val = 1'b0;
		wait (next_check == N_ENT);
		// a few idle cycles to see the exponent hold
		repeat (4) @(posedge clk);
		$display("tests ok %0d, tests wrong %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	localparam int HALF_NS = 20;

	initial begin
		clk_o = 1'b0;
		forever #HALF_NS clk_o = ~clk_o;
	end

endmodule
